//--- Bender.yml
package:
  name: dual_chan_fifo

sources:
  - include_dirs:
      - logic
    files:
      - logic/fifo_ptr_pkg.sv
      - logic/fifo_data_pkg.sv
      - logic/chan_rd_if.sv
      - logic/dual_port_ram.sv
      - logic/fifo_wr_ctrl.sv
      - logic/fifo_rd_ctrl.sv
      - logic/read_arbiter.sv
      - logic/dual_chan_fifo.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - testbench/fifo_assertions.sv
      - testbench/tb_dual_chan_fifo.sv

//--- logic/chan_rd_if.sv
`timescale 1ns/1ps

interface chan_rd_if;

  import fifo_data_pkg::*;

  logic      req;     // level, held until gnt
  ram_addr_u addr;
  logic      gnt;     // one-cycle pulse
  data_t     data;
  logic      valid;   // one cycle after gnt

  modport chan (
    output req,
    output addr,
    input  gnt,
    input  data,
    input  valid
  );

  modport arb (
    input  req,
    input  addr,
    output gnt,
    output data,
    output valid
  );

endinterface

//--- logic/dual_chan_fifo.sv
`timescale 1ns/1ps
`include "fifo_defines.svh"

module dual_chan_fifo (
  // write domain
  input  logic                             wr_clk,
  input  logic                             wr_rst_n,
  input  logic                             wr_en,
  input  fifo_data_pkg::chan_t             wr_chan,
  input  fifo_data_pkg::data_t             wr_data,
  output logic [`FIFO_NUM_CHAN-1:0]        full,
  output logic [`FIFO_NUM_CHAN-1:0]        afull,
  // read domain
  input  logic                             rd_clk,
  input  logic                             rd_rst_n,
  input  logic [`FIFO_NUM_CHAN-1:0]        rd_en,
  output fifo_data_pkg::data_t             rd_data,
  output logic [`FIFO_NUM_CHAN-1:0]        rd_valid,
  output logic [`FIFO_NUM_CHAN-1:0]        empty,
  output logic [`FIFO_NUM_CHAN-1:0]        aempty
);

  import fifo_ptr_pkg::*;
  import fifo_data_pkg::*;

  ptr_t [`FIFO_NUM_CHAN-1:0] wr_gray;
  ptr_t [`FIFO_NUM_CHAN-1:0] rd_gray;
  logic                      we;
  ram_addr_u                 waddr;
  data_t                     wdata;
  ram_addr_u                 raddr;
  data_t                     rdata;

  chan_rd_if chan0_if ();
  chan_rd_if chan1_if ();

  fifo_wr_ctrl u_wr_ctrl (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_chan  (wr_chan),
    .wr_data  (wr_data),
    .rd_gray  (rd_gray),
    .wr_gray  (wr_gray),
    .we       (we),
    .waddr    (waddr),
    .wdata    (wdata),
    .full     (full),
    .afull    (afull)
  );

  dual_port_ram u_ram (
    .wr_clk (wr_clk),
    .we     (we),
    .waddr  (waddr),
    .wdata  (wdata),
    .rd_clk (rd_clk),
    .raddr  (raddr),
    .rdata  (rdata)
  );

  fifo_rd_ctrl #(.CHAN_ID(0)) u_rd_ctrl0 (
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en[0]),
    .wr_gray  (wr_gray[0]),
    .rd_gray  (rd_gray[0]),
    .empty    (empty[0]),
    .aempty   (aempty[0]),
    .port     (chan0_if.chan)
  );

  fifo_rd_ctrl #(.CHAN_ID(1)) u_rd_ctrl1 (
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en[1]),
    .wr_gray  (wr_gray[1]),
    .rd_gray  (rd_gray[1]),
    .empty    (empty[1]),
    .aempty   (aempty[1]),
    .port     (chan1_if.chan)
  );

  read_arbiter u_arb (
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .ch0      (chan0_if.arb),
    .ch1      (chan1_if.arb),
    .raddr    (raddr),
    .rdata    (rdata)
  );

  // pick the returning channel off the shared bus
  assign rd_valid = {chan1_if.valid, chan0_if.valid};
  assign rd_data  = chan1_if.valid ? chan1_if.data : chan0_if.data;

endmodule

//--- logic/dual_port_ram.sv
`timescale 1ns/1ps

module dual_port_ram (
  input  logic                    wr_clk,
  input  logic                    we,
  input  fifo_data_pkg::ram_addr_u waddr,
  input  fifo_data_pkg::data_t     wdata,
  input  logic                    rd_clk,
  input  fifo_data_pkg::ram_addr_u raddr,
  output fifo_data_pkg::data_t     rdata
);

  import fifo_data_pkg::*;

  data_t mem [NUM_ROWS];

  always_ff @(posedge wr_clk) begin
    if (we) begin
      mem[waddr.row] <= wdata;
    end
  end

  // registered read, one rd_clk of latency
  always_ff @(posedge rd_clk) begin
    rdata <= mem[raddr.row];
  end

endmodule

//--- logic/fifo_data_pkg.sv
`include "fifo_defines.svh"

package fifo_data_pkg;

  localparam int CHAN_W   = $clog2(`FIFO_NUM_CHAN);
  localparam int ROW_W    = CHAN_W + fifo_ptr_pkg::SLOT_W;
  localparam int NUM_ROWS = 2 ** ROW_W;

  typedef logic [`FIFO_DATA_WIDTH-1:0] data_t;
  typedef logic [CHAN_W-1:0]           chan_t;

  // controller view of a RAM address
  typedef struct packed {
    chan_t               chan;          // selects the channel region
    fifo_ptr_pkg::slot_t slot;
  } ram_field_t;

  // RAM sees a flat row, controllers fill the fields
  typedef union packed {
    logic [ROW_W-1:0] row;
    ram_field_t       field;
  } ram_addr_u;

endpackage

//--- logic/fifo_defines.svh
`ifndef FIFO_DEFINES_SVH
`define FIFO_DEFINES_SVH

// word and channel geometry
`define FIFO_DATA_WIDTH 8
`define FIFO_CHAN_DEPTH 16   // power of two
`define FIFO_NUM_CHAN   2

// flag thresholds in words held
`define FIFO_AFULL      14
`define FIFO_AEMPTY     1

`endif

//--- logic/fifo_ptr_pkg.sv
`include "fifo_defines.svh"

package fifo_ptr_pkg;

  localparam int SLOT_W = $clog2(`FIFO_CHAN_DEPTH);
  localparam int PTR_W  = SLOT_W + 1;        // extra wrap bit

  typedef logic [PTR_W-1:0]  ptr_t;
  typedef logic [SLOT_W-1:0] slot_t;

  function automatic ptr_t bin2gray(ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  function automatic ptr_t gray2bin(ptr_t gray);
    ptr_t bin;
    bin[PTR_W-1] = gray[PTR_W-1];
    for (int i = PTR_W - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];       // running xor from msb down
    end
    return bin;
  endfunction

endpackage

//--- logic/fifo_rd_ctrl.sv
`timescale 1ns/1ps
`include "fifo_defines.svh"

module fifo_rd_ctrl #(
  parameter int CHAN_ID = 0
) (
  input  logic               rd_clk,
  input  logic               rd_rst_n,
  input  logic               rd_en,
  input  fifo_ptr_pkg::ptr_t wr_gray,
  output fifo_ptr_pkg::ptr_t rd_gray,
  output logic               empty,
  output logic               aempty,
  chan_rd_if.chan            port
);

  import fifo_ptr_pkg::*;
  import fifo_data_pkg::*;

  ptr_t rd_bin;
  ptr_t rd_bin_nxt;
  ptr_t wsync1;
  ptr_t wsync2;
  ptr_t wr_bin;
  ptr_t used;
  logic req_q;
  logic rd_acc;

  // one request in flight at most
  assign rd_acc = rd_en && !empty && !req_q;

  assign rd_bin_nxt = port.gnt ? rd_bin + 1'b1 : rd_bin;

  assign wr_bin = gray2bin(wsync2);
  assign used   = wr_bin - rd_bin;
  assign empty  = used == '0;
  assign aempty = used <= `FIFO_AEMPTY;

  // address stays put until gnt moves rd_bin
  always_comb begin
    port.req        = req_q;
    port.addr.field = '{chan: chan_t'(CHAN_ID), slot: slot_t'(rd_bin)};
  end

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_bin  <= '0;
      rd_gray <= '0;
      wsync1  <= '0;
      wsync2  <= '0;
      req_q   <= 1'b0;
    end else begin
      rd_bin  <= rd_bin_nxt;
      rd_gray <= bin2gray(rd_bin_nxt);
      wsync1  <= wr_gray;      // write pointer into rd_clk
      wsync2  <= wsync1;
      if (port.gnt) begin
        req_q <= 1'b0;         // drop with the pointer step
      end else if (rd_acc) begin
        req_q <= 1'b1;
      end
    end
  end

endmodule

//--- logic/fifo_wr_ctrl.sv
`timescale 1ns/1ps
`include "fifo_defines.svh"

module fifo_wr_ctrl (
  input  logic                                      wr_clk,
  input  logic                                      wr_rst_n,
  input  logic                                      wr_en,
  input  fifo_data_pkg::chan_t                      wr_chan,
  input  fifo_data_pkg::data_t                      wr_data,
  input  fifo_ptr_pkg::ptr_t [`FIFO_NUM_CHAN-1:0]   rd_gray,
  output fifo_ptr_pkg::ptr_t [`FIFO_NUM_CHAN-1:0]   wr_gray,
  output logic                                      we,
  output fifo_data_pkg::ram_addr_u                  waddr,
  output fifo_data_pkg::data_t                      wdata,
  output logic [`FIFO_NUM_CHAN-1:0]                 full,
  output logic [`FIFO_NUM_CHAN-1:0]                 afull
);

  import fifo_ptr_pkg::*;
  import fifo_data_pkg::*;

  localparam int NC = `FIFO_NUM_CHAN;

  logic              wr_acc;
  ptr_t [NC-1:0]     bin_q;
  ptr_t [NC-1:0]     bin_nxt;
  ptr_t [NC-1:0]     gray_nxt;
  ptr_t [NC-1:0]     rsync1;
  ptr_t [NC-1:0]     rsync2;
  ptr_t [NC-1:0]     used_nxt;
  logic [NC-1:0]     full_nxt;
  logic [NC-1:0]     afull_nxt;

  assign wr_acc = wr_en && !full[wr_chan];   // drop writes to a full channel

  always_comb begin
    for (int c = 0; c < NC; c++) begin
      bin_nxt[c]   = (wr_acc && wr_chan == c) ? bin_q[c] + 1'b1 : bin_q[c];
      gray_nxt[c]  = bin2gray(bin_nxt[c]);
      // full when the gray pointers differ only in the two msbs
      full_nxt[c]  = gray_nxt[c] == {~rsync2[c][PTR_W-1 -: 2], rsync2[c][PTR_W-3:0]};
      used_nxt[c]  = bin_nxt[c] - gray2bin(rsync2[c]);
      afull_nxt[c] = used_nxt[c] >= `FIFO_AFULL;
    end
  end

  // RAM write port
  always_comb begin
    we               = wr_acc;
    waddr.field.chan = wr_chan;
    waddr.field.slot = slot_t'(bin_q[wr_chan]);
    wdata            = wr_data;
  end

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      bin_q   <= '0;
      wr_gray <= '0;
      rsync1  <= '0;
      rsync2  <= '0;
      full    <= '0;
      afull   <= '0;
    end else begin
      bin_q   <= bin_nxt;
      wr_gray <= gray_nxt;
      rsync1  <= rd_gray;      // read pointers into wr_clk
      rsync2  <= rsync1;
      full    <= full_nxt;
      afull   <= afull_nxt;
    end
  end

endmodule

//--- logic/read_arbiter.sv
`timescale 1ns/1ps

module read_arbiter (
  input  logic                     rd_clk,
  input  logic                     rd_rst_n,
  chan_rd_if.arb                   ch0,
  chan_rd_if.arb                   ch1,
  output fifo_data_pkg::ram_addr_u raddr,
  input  fifo_data_pkg::data_t     rdata
);

  import fifo_data_pkg::*;

  chan_t last_q;     // channel granted last
  chan_t win;
  logic  any_gnt;
  logic  vld_q;
  chan_t vld_chan;

  always_comb begin
    any_gnt = ch0.req || ch1.req;
    // ch1 wins when alone or when ch0 went last
    if (ch1.req && (!ch0.req || last_q == chan_t'(0))) begin
      win = chan_t'(1);
    end else begin
      win = chan_t'(0);
    end
    ch0.gnt = any_gnt && win == chan_t'(0);
    ch1.gnt = any_gnt && win == chan_t'(1);
    raddr   = (win == chan_t'(1)) ? ch1.addr : ch0.addr;
  end

  // return path, one cycle behind the grant
  always_comb begin
    ch0.valid = vld_q && vld_chan == chan_t'(0);
    ch1.valid = vld_q && vld_chan == chan_t'(1);
    ch0.data  = ch0.valid ? rdata : '0;   // only the returning channel sees the word
    ch1.data  = ch1.valid ? rdata : '0;
  end

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      last_q   <= chan_t'(1);   // ch0 first
      vld_q    <= 1'b0;
      vld_chan <= chan_t'(0);
    end else begin
      vld_q <= any_gnt;
      if (any_gnt) begin
        last_q   <= win;
        vld_chan <= win;
      end
    end
  end

endmodule

//--- sources.f
+incdir+logic
logic/fifo_ptr_pkg.sv
logic/fifo_data_pkg.sv
logic/chan_rd_if.sv
logic/dual_port_ram.sv
logic/fifo_wr_ctrl.sv
logic/fifo_rd_ctrl.sv
logic/read_arbiter.sv
logic/dual_chan_fifo.sv
testbench/fifo_assertions.sv
testbench/tb_dual_chan_fifo.sv

//--- testbench/fifo_assertions.sv
`timescale 1ns/1ps

module fifo_assertions (
  input logic               clk,
  input logic               rst_n,
  input logic [1:0]         req,
  input logic [1:0]         gnt,
  input logic [1:0]         valid,
  input logic [1:0]         empty,
  input fifo_ptr_pkg::ptr_t gray_a,
  input fifo_ptr_pkg::ptr_t gray_b
);

  int err_cnt = 0;   // failures seen so far

  a_gnt_excl: assert property (@(posedge clk) disable iff (!rst_n) !(gnt[0] && gnt[1]))
    else begin
      $error("both grants high in one cycle");
      err_cnt++;
    end

  for (genvar i = 0; i < 2; i++) begin : g_chan
    a_gnt_req: assert property (@(posedge clk) disable iff (!rst_n) gnt[i] |-> req[i])
      else begin
        $error("grant %0d without a request", i);
        err_cnt++;
      end

    // valid is exactly the grant delayed by one
    a_valid_gnt: assert property (@(posedge clk) disable iff (!rst_n) valid[i] == $past(gnt[i]))
      else begin
        $error("valid %0d does not follow its grant", i);
        err_cnt++;
      end

    a_req_rise: assert property (@(posedge clk) disable iff (!rst_n)
                                 $rose(req[i]) |-> !$past(empty[i]))
      else begin
        $error("request %0d raised while empty", i);
        err_cnt++;
      end
  end

  a_gray_step: assert property (@(posedge clk) disable iff (!rst_n)
                                $countones(gray_a ^ $past(gray_a)) <= 1 &&
                                $countones(gray_b ^ $past(gray_b)) <= 1)
    else begin
      $error("gray pointer moved by more than one bit");
      err_cnt++;
    end

endmodule

bind read_arbiter fifo_assertions arb_chk (
  .clk    (rd_clk),
  .rst_n  (rd_rst_n),
  .req    ({ch1.req, ch0.req}),
  .gnt    ({ch1.gnt, ch0.gnt}),
  .valid  ({ch1.valid, ch0.valid}),
  .empty  (2'b00),
  .gray_a ('0),
  .gray_b ('0)
);

bind fifo_rd_ctrl fifo_assertions rd_chk (
  .clk    (rd_clk),
  .rst_n  (rd_rst_n),
  .req    ({1'b0, port.req}),
  .gnt    ({1'b0, port.gnt}),
  .valid  ({1'b0, port.valid}),
  .empty  ({1'b0, empty}),
  .gray_a (rd_gray),
  .gray_b (wsync2)        // synced write pointer
);

//--- testbench/tb_dual_chan_fifo.sv
`timescale 1ns/1ps
`include "fifo_defines.svh"

module tb_dual_chan_fifo;

  import fifo_data_pkg::*;

  localparam int NC          = `FIFO_NUM_CHAN;
  localparam int TIMEOUT_CYC = 4000;

  logic          wr_clk;
  logic          wr_rst_n;
  logic          wr_en;
  chan_t         wr_chan;
  data_t         wr_data;
  logic [NC-1:0] full;
  logic [NC-1:0] afull;
  logic          rd_clk;
  logic          rd_rst_n;
  logic [NC-1:0] rd_en;
  data_t         rd_data;
  logic [NC-1:0] rd_valid;
  logic [NC-1:0] empty;
  logic [NC-1:0] aempty;

  data_t  ref_q [NC][$];   // words stored per channel
  string  test_name;
  integer seed = 66564;
  int     cycle_cnt = 0;

  dual_chan_fifo dut (.*);

  initial begin
    rd_clk = 1'b0;
    forever #5 rd_clk = ~rd_clk;
  end

  initial begin
    wr_clk = 1'b0;
    forever #7 wr_clk = ~wr_clk;
  end

  task automatic stop_run();
    $display("test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic fail_plain(input string msg);
    $display("Error in %s: %s", test_name, msg);
    stop_run();
  endtask

  task automatic fail_value(input string what, input int exp, input int act);
    $display("Fail %s: %s expected %0h actual %0h", test_name, what, exp, act);
    stop_run();
  endtask

  function automatic int proto_errs();
    return dut.u_arb.arb_chk.err_cnt + dut.u_rd_ctrl0.rd_chk.err_cnt +
           dut.u_rd_ctrl1.rd_chk.err_cnt;
  endfunction

  task automatic write_word(input int c, input int d);
    @(posedge wr_clk);
    wr_en   <= 1'b1;
    wr_chan <= chan_t'(c);
    wr_data <= data_t'(d);
    @(posedge wr_clk);
    wr_en   <= 1'b0;
  endtask

  // uncontended read, rd_valid two cycles after rd_en is taken
  task automatic read_word(input int c);
    int waits;
    waits = 0;
    @(posedge rd_clk);
    while (empty[c]) begin
      @(posedge rd_clk);
    end
    rd_en[c] <= 1'b1;
    @(posedge rd_clk);
    rd_en[c] <= 1'b0;
    while (!rd_valid[c]) begin
      @(posedge rd_clk);
      waits++;
    end
    assert (waits == 2) else fail_value($sformatf("read latency ch%0d", c), 2, waits);
  endtask

  task automatic read_both();
    int cyc;
    int seen;
    int first_cyc;
    int last_cyc;
    cyc = 0;
    seen = 0;
    first_cyc = 0;
    last_cyc = 0;
    @(posedge rd_clk);
    rd_en <= '1;
    @(posedge rd_clk);
    rd_en <= '0;
    while (seen < 2) begin
      @(posedge rd_clk);
      cyc++;
      if (rd_valid != '0) begin
        if (seen == 0) begin
          first_cyc = cyc;
        end
        last_cyc = cyc;
        seen += $countones(rd_valid);
      end
    end
    assert (last_cyc - first_cyc == 1)
      else fail_value("rd_valid spacing", 1, last_cyc - first_cyc);
  endtask

  task automatic check_wr_flags();
    for (int c = 0; c < NC; c++) begin
      assert (full[c] == (ref_q[c].size() >= `FIFO_CHAN_DEPTH))
        else fail_value($sformatf("full[%0d]", c), ref_q[c].size() >= `FIFO_CHAN_DEPTH, full[c]);
      assert (afull[c] == (ref_q[c].size() >= `FIFO_AFULL))
        else fail_value($sformatf("afull[%0d]", c), ref_q[c].size() >= `FIFO_AFULL, afull[c]);
    end
  endtask

  // wait out gray register and two sync stages on both sides
  task automatic settle_and_check();
    repeat (5) @(posedge wr_clk);
    @(negedge rd_clk);
    for (int c = 0; c < NC; c++) begin
      assert (empty[c] == (ref_q[c].size() == 0))
        else fail_value($sformatf("empty[%0d]", c), ref_q[c].size() == 0, empty[c]);
      assert (aempty[c] == (ref_q[c].size() <= `FIFO_AEMPTY))
        else fail_value($sformatf("aempty[%0d]", c), ref_q[c].size() <= `FIFO_AEMPTY, aempty[c]);
    end
    @(negedge wr_clk);
    check_wr_flags();
  endtask

  always @(posedge wr_clk) begin
    if (wr_rst_n && wr_en && !full[wr_chan]) begin
      ref_q[wr_chan].push_back(wr_data);
    end
  end

  always @(posedge rd_clk) begin
    data_t exp_word;
    for (int c = 0; c < NC; c++) begin
      if (rd_rst_n && rd_valid[c]) begin
        assert (ref_q[c].size() != 0) begin
          exp_word = ref_q[c].pop_front();
          assert (rd_data == exp_word)
            else fail_value($sformatf("rd_data ch%0d", c), exp_word, rd_data);
        end else begin
          fail_plain($sformatf("rd_valid on channel %0d with nothing stored", c));
        end
      end
    end
  end

  always @(posedge rd_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    assert (cycle_cnt < TIMEOUT_CYC)
      else fail_plain($sformatf("run timed out after %0d rd_clk cycles", cycle_cnt));
    assert (proto_errs() == 0) else fail_plain("a bound protocol assertion fired");
  end

  initial begin
    wr_rst_n  = 1'b0;
    rd_rst_n  = 1'b0;
    wr_en     = 1'b0;
    wr_chan   = '0;
    wr_data   = '0;
    rd_en     = '0;
    test_name = "reset";
    repeat (10) @(posedge rd_clk);
    rd_rst_n <= 1'b1;
    wr_rst_n <= 1'b1;
    settle_and_check();

    test_name = "order";
    for (int i = 0; i < 8; i++) begin
      write_word(i % 2, $random(seed));   // interleaved channels
    end
    for (int i = 0; i < 4; i++) begin
      read_word(0);
      read_word(1);
    end
    settle_and_check();

    test_name = "full_drop";
    for (int i = 0; i < 19; i++) begin
      write_word(0, $random(seed));   // last three land on a full channel
      @(negedge wr_clk);
      check_wr_flags();
    end
    assert (ref_q[0].size() == 16) else fail_value("stored words", 16, ref_q[0].size());
    repeat (16) read_word(0);
    settle_and_check();

    test_name = "empty_read";
    @(posedge rd_clk);
    rd_en[1] <= 1'b1;
    @(posedge rd_clk);
    rd_en[1] <= 1'b0;
    repeat (4) @(posedge rd_clk);
    write_word(1, $random(seed));
    write_word(1, $random(seed));
    settle_and_check();
    read_word(1);
    settle_and_check();
    read_word(1);
    settle_and_check();

    test_name = "contention";
    for (int i = 0; i < 2; i++) begin
      write_word(0, $random(seed));
      write_word(1, $random(seed));
    end
    settle_and_check();
    repeat (2) read_both();
    settle_and_check();

    test_name = "random";
    fork
      begin
        repeat (150) begin
          write_word($random(seed) & 1, $random(seed));
          if ($random(seed) & 1) begin
            @(posedge wr_clk);
          end
        end
      end
      begin
        int c;
        repeat (150) begin
          c = $random(seed) & 1;
          if (!empty[c]) begin
            read_word(c);
          end else begin
            @(posedge rd_clk);
          end
        end
      end
    join
    settle_and_check();
    // drain until the DUT itself reports empty
    for (int c = 0; c < NC; c++) begin
      while (!empty[c]) begin
        read_word(c);
      end
    end
    settle_and_check();
    for (int c = 0; c < NC; c++) begin
      assert (ref_q[c].size() == 0)
        else fail_value($sformatf("words left ch%0d", c), 0, ref_q[c].size());
    end

    if (proto_errs() == 0) begin
      $display("test passed");
      $finish;
    end else begin
      fail_plain("a bound protocol assertion fired");
    end
  end

endmodule
